// File: hdl/flac_settings.svh
`ifndef FLAC_SETTINGS_SVH
`define FLAC_SETTINGS_SVH

// memory word width
`define FLAC_WORD_W 16

// word address width, 4k words of stream
`define FLAC_ADDR_W 12

// decoded residual width
`define FLAC_RES_W 16

// residual beats the consumer can take after reset
`define FLAC_CREDITS 4

`endif

// File: hdl/flac_pkg.sv
`include "flac_settings.svh"

package flac_pkg;

        // job handed over with start
        typedef struct packed {
                logic [15:0] n_samples;          // block size
                logic [3:0]  pred_order;         // warm-up samples not in residual
                logic [15:0] start_word;         // word holding the method field
                logic [3:0]  start_bit;          // MSBs already used in that word
        } residual_cfg_t;

        // one decoded residual on the output
        typedef struct packed {
                logic signed [`FLAC_RES_W-1:0] residual;
                logic                          part_last;   // end of partition
                logic                          frame_last;  // end of job
        } residual_beat_t;

        // what the bit reader shows to the controller
        typedef struct packed {
                logic [`FLAC_WORD_W-1:0] bits;   // next stream bits, MSB first
                logic [4:0]              avail;  // valid bits in bits, 0 to 16
        } bit_window_t;

endpackage

// File: hdl/stream_ram.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module stream_ram (
        input  logic                    iClock,
        input  logic                    we,
        input  logic [`FLAC_ADDR_W-1:0] waddr,
        input  logic [`FLAC_WORD_W-1:0] wdata,
        input  logic [`FLAC_ADDR_W-1:0] raddr,
        output logic [`FLAC_WORD_W-1:0] rdata
);

        logic [`FLAC_WORD_W-1:0] mem [0:(2**`FLAC_ADDR_W)-1];

        always_ff @(posedge iClock) begin
                if (we) begin
                        mem[waddr] <= wdata;       // load port
                end
        end

        // registered read, data one cycle after the address
        always_ff @(posedge iClock) begin
                rdata <= mem[raddr];
        end

endmodule

// File: hdl/bit_reader.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module bit_reader (
        input  logic                    iClock,
        input  logic                    rst,
        input  logic                    restart,
        input  logic [`FLAC_ADDR_W-1:0] start_word,
        input  logic [3:0]              start_bit,
        input  logic [4:0]              consume,
        output flac_pkg::bit_window_t   window,
        output logic [`FLAC_ADDR_W-1:0] raddr,
        input  logic [`FLAC_WORD_W-1:0] rdata
);

        logic [31:0]             buf_q;          // left aligned, zeros below fill
        logic [5:0]              fill_q;
        logic [3:0]              skip_q;         // MSBs to drop from next word
        logic                    pend_q;         // read in flight
        logic                    active_q;
        logic [`FLAC_ADDR_W-1:0] addr_q;

        logic [31:0]             buf_shift;
        logic [5:0]              fill_after;
        logic [`FLAC_WORD_W-1:0] word_trim;
        logic [4:0]              word_cnt;
        logic [31:0]             word_al;
        logic [5:0]              fill_new;
        logic                    issue;

        always_comb begin
                buf_shift  = buf_q << consume;
                fill_after = fill_q - {1'b0, consume};
                word_trim  = rdata << skip_q;                  // first word may start late
                word_cnt   = pend_q ? (5'd16 - {1'b0, skip_q}) : 5'd0;
                word_al    = {word_trim, 16'b0} >> fill_after; // lands right below valid bits
                fill_new   = fill_after + {1'b0, word_cnt};
                // room for one more word once this one is merged
                issue      = active_q && (fill_new <= 6'd16);
        end

        always_ff @(posedge iClock) begin
                if (rst) begin
                        fill_q   <= '0;
                        skip_q   <= '0;
                        pend_q   <= 1'b0;
                        active_q <= 1'b0;
                        addr_q   <= '0;
                end else if (restart) begin
                        buf_q    <= '0;
                        fill_q   <= '0;
                        skip_q   <= start_bit;
                        pend_q   <= 1'b0;           // drop a stale word
                        active_q <= 1'b1;
                        addr_q   <= start_word;
                end else begin
                        fill_q <= fill_new;
                        if (pend_q) begin
                                buf_q  <= buf_shift | word_al;
                                skip_q <= '0;
                        end else begin
                                buf_q <= buf_shift;
                        end
                        pend_q <= issue;
                        if (issue) begin
                                addr_q <= addr_q + 1'b1;
                        end
                end
        end

        assign raddr        = addr_q;           // ram samples it every cycle
        assign window.bits  = buf_q[31:16];
        assign window.avail = (fill_q >= 6'd16) ? 5'd16 : fill_q[4:0];

endmodule

// File: hdl/rice_decoder.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module rice_decoder (
        input  logic                          iClock,
        input  logic                          rst,
        input  logic                          clear,
        input  logic                          enable,
        input  logic                          bit_in,
        input  logic [3:0]                    rice_param,
        output logic signed [`FLAC_RES_W-1:0] sample,
        output logic                          sample_valid
);

        logic                   low_phase;      // past the stop bit
        logic [`FLAC_RES_W-1:0] q_q;            // unary quotient so far
        logic [`FLAC_RES_W-1:0] low_q;          // low bits so far
        logic [3:0]             left_q;         // low bits still to come

        logic [`FLAC_RES_W-1:0] low_full;
        logic [`FLAC_RES_W-1:0] u;
        logic [`FLAC_RES_W-1:0] half;

        always_comb begin
                low_full = low_phase ? {low_q[`FLAC_RES_W-2:0], bit_in} : '0;
                u        = (q_q << rice_param) | low_full;
                half     = {1'b0, u[`FLAC_RES_W-1:1]};
                // zig-zag, odd values are negative
                sample   = u[0] ? $signed(~half) : $signed(half);
                sample_valid = enable &&
                               ((!low_phase && bit_in && rice_param == 4'd0) ||
                                (low_phase && left_q == 4'd1));
        end

        always_ff @(posedge iClock) begin
                if (rst || clear) begin
                        low_phase <= 1'b0;
                        q_q       <= '0;
                        low_q     <= '0;
                        left_q    <= '0;
                end else if (enable) begin
                        if (sample_valid) begin
                                low_phase <= 1'b0;       // rearm for next sample
                                q_q       <= '0;
                                low_q     <= '0;
                        end else if (!low_phase) begin
                                if (bit_in) begin
                                        low_phase <= 1'b1;
                                        left_q    <= rice_param;
                                end else begin
                                        q_q <= q_q + 1'b1;
                                end
                        end else begin
                                low_q  <= {low_q[`FLAC_RES_W-2:0], bit_in};
                                left_q <= left_q - 1'b1;
                        end
                end
        end

endmodule

// File: hdl/residual_decoder.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module residual_decoder (
        input  logic                     iClock,
        input  logic                     rst,
        input  logic                     start,
        input  flac_pkg::residual_cfg_t  cfg,
        input  flac_pkg::bit_window_t    window,
        output logic [4:0]               consume,
        output logic                     restart,
        output logic [`FLAC_ADDR_W-1:0]  start_word,
        output logic [3:0]               start_bit,
        input  logic                     credit_return,
        output logic                     out_valid,
        output flac_pkg::residual_beat_t out_beat,
        output logic                     frame_done,
        output logic                     busy
);
        import flac_pkg::*;

        localparam int CRED_W = $clog2(`FLAC_CREDITS + 1);

        typedef enum logic [2:0] {
                S_IDLE,
                S_METHOD,
                S_ORDER,
                S_PARAM,
                S_RESID
        } state_t;

        state_t                        state;
        residual_cfg_t                 cfg_q;
        logic [3:0]                    order_q;
        logic [3:0]                    param_q;
        logic [15:0]                   part_q;          // partition index
        logic [15:0]                   part_left_q;     // samples left in partition
        logic [CRED_W-1:0]             credits;

        logic                          go;
        logic                          rice_en;
        logic                          rice_valid;
        logic signed [`FLAC_RES_W-1:0] rice_sample;
        logic [15:0]                   part_size;
        logic [15:0]                   last_part;
        logic                          part_end;

        rice_decoder i_rice_decoder (
                .iClock       (iClock),
                .rst          (rst),
                .clear        (restart),
                .enable       (rice_en),
                .bit_in       (window.bits[15]),
                .rice_param   (param_q),
                .sample       (rice_sample),
                .sample_valid (rice_valid)
        );

        assign restart    = start && (state == S_IDLE);
        assign start_word = cfg.start_word[`FLAC_ADDR_W-1:0];
        assign start_bit  = cfg.start_bit;
        assign busy       = (state != S_IDLE);

        always_comb begin
                go        = (credits != '0);            // no credit, no progress
                part_size = cfg_q.n_samples >> order_q;
                if (part_q == 16'd0) begin
                        part_size = part_size - {12'd0, cfg_q.pred_order};
                end
                last_part = (16'd1 << order_q) - 16'd1;
                part_end  = (part_left_q == 16'd1);
                rice_en   = 1'b0;
                consume   = 5'd0;
                case (state)
                        S_METHOD: if (go && window.avail >= 5'd2) consume = 5'd2;
                        S_ORDER:  if (go && window.avail >= 5'd4) consume = 5'd4;
                        S_PARAM:  if (go && window.avail >= 5'd4) consume = 5'd4;
                        S_RESID: begin
                                rice_en = go && (window.avail != 5'd0);
                                consume = {4'd0, rice_en};       // one bit per cycle
                        end
                        default: consume = 5'd0;
                endcase
        end

        // beat leaves in the cycle the last bit of the sample goes in
        assign out_valid           = rice_valid;
        assign out_beat.residual   = rice_sample;
        assign out_beat.part_last  = part_end;
        assign out_beat.frame_last = part_end && (part_q == last_part);
        assign frame_done          = out_valid && out_beat.frame_last;

        always_ff @(posedge iClock) begin
                if (rst) begin
                        state <= S_IDLE;
                end else begin
                        case (state)
                                S_IDLE: if (restart) begin
                                        cfg_q <= cfg;
                                        state <= S_METHOD;
                                end
                                S_METHOD: if (consume != 5'd0) begin
                                        state <= S_ORDER;   // method is ignored
                                end
                                S_ORDER: if (consume != 5'd0) begin
                                        order_q <= window.bits[15:12];
                                        part_q  <= 16'd0;
                                        state   <= S_PARAM;
                                end
                                S_PARAM: if (consume != 5'd0) begin
                                        param_q     <= window.bits[15:12];
                                        part_left_q <= part_size;
                                        state       <= S_RESID;
                                end
                                S_RESID: if (rice_valid) begin
                                        part_left_q <= part_left_q - 16'd1;
                                        if (frame_done) begin
                                                state <= S_IDLE;
                                        end else if (part_end) begin
                                                part_q <= part_q + 16'd1;
                                                state  <= S_PARAM;
                                        end
                                end
                                default: state <= S_IDLE;
                        endcase
                end
        end

        always_ff @(posedge iClock) begin
                if (rst) begin
                        credits <= CRED_W'(`FLAC_CREDITS);
                end else begin
                        case ({out_valid, credit_return})
                                2'b10:   credits <= credits - 1'b1;
                                2'b01:   credits <= credits + 1'b1;
                                default: credits <= credits;    // none or both
                        endcase
                end
        end

endmodule

// File: hdl/residual_top.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module residual_top (
        input  logic                     iClock,
        input  logic                     rst,
        input  logic                     start,
        input  flac_pkg::residual_cfg_t  cfg,
        input  logic                     load_we,
        input  logic [`FLAC_ADDR_W-1:0]  load_addr,
        input  logic [`FLAC_WORD_W-1:0]  load_data,
        input  logic                     credit_return,
        output logic                     out_valid,
        output flac_pkg::residual_beat_t out_beat,
        output logic                     frame_done,
        output logic                     busy
);
        import flac_pkg::*;

        bit_window_t             window;
        logic [4:0]              consume;
        logic                    restart;
        logic [`FLAC_ADDR_W-1:0] start_word;
        logic [3:0]              start_bit;
        logic [`FLAC_ADDR_W-1:0] raddr;
        logic [`FLAC_WORD_W-1:0] rdata;

        stream_ram i_stream_ram (
                .iClock (iClock),
                .we     (load_we),
                .waddr  (load_addr),
                .wdata  (load_data),
                .raddr  (raddr),
                .rdata  (rdata)
        );

        bit_reader i_bit_reader (
                .iClock     (iClock),
                .rst        (rst),
                .restart    (restart),
                .start_word (start_word),
                .start_bit  (start_bit),
                .consume    (consume),
                .window     (window),
                .raddr      (raddr),
                .rdata      (rdata)
        );

        residual_decoder i_residual_decoder (
                .iClock        (iClock),
                .rst           (rst),
                .start         (start),
                .cfg           (cfg),
                .window        (window),
                .consume       (consume),
                .restart       (restart),
                .start_word    (start_word),
                .start_bit     (start_bit),
                .credit_return (credit_return),
                .out_valid     (out_valid),
                .out_beat      (out_beat),
                .frame_done    (frame_done),
                .busy          (busy)
        );

endmodule

// File: test/residual_assertions.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module residual_assertions #(
        parameter int CRED_W = $clog2(`FLAC_CREDITS + 1)
) (
        input logic              iClock,
        input logic              rst,
        input logic              restart,
        input logic              out_valid,
        input logic              credit_return,
        input logic [CRED_W-1:0] credits,
        input logic              frame_done,
        input logic [15:0]       n_samples,
        input logic [3:0]        pred_order
);

        logic [CRED_W-1:0] model_cred;          // credits as the consumer counts them
        logic [15:0]       beat_cnt;            // beats since the job started
        int                failures = 0;

        always @(posedge iClock) begin
                if (rst) begin
                        model_cred <= CRED_W'(`FLAC_CREDITS);
                end else begin
                        model_cred <= model_cred - CRED_W'(out_valid) + CRED_W'(credit_return);
                end
        end

        always @(posedge iClock) begin
                if (rst || restart) begin
                        beat_cnt <= '0;
                end else if (out_valid) begin
                        beat_cnt <= beat_cnt + 16'd1;
                end
        end

        // a beat spends one credit, so one must be left
        property valid_needs_credit;
                @(posedge iClock) disable iff (rst) out_valid |-> (model_cred != '0);
        endproperty

        property credits_bounded;
                @(posedge iClock) disable iff (rst) credits <= CRED_W'(`FLAC_CREDITS);
        endproperty

        // the job ends on its last residual
        property done_at_block_end;
                @(posedge iClock) disable iff (rst)
                        frame_done |-> (beat_cnt + 16'd1 == n_samples - {12'd0, pred_order});
        endproperty

        assert property (valid_needs_credit)
                else begin
                        $error("out_valid raised with no credit left");
                        failures++;
                end
        assert property (credits_bounded)
                else begin
                        $error("credit counter above its reset value");
                        failures++;
                end
        assert property (done_at_block_end)
                else begin
                        $error("frame_done before or after the last residual of the job");
                        failures++;
                end

endmodule

// File: test/residual_tb.sv
`timescale 1ns/100ps
`include "flac_settings.svh"

module residual_tb;
        import flac_pkg::*;

        logic                    iClock;
        logic                    rst;
        logic                    start;
        residual_cfg_t           cfg;
        logic                    load_we;
        logic [`FLAC_ADDR_W-1:0] load_addr;
        logic [`FLAC_WORD_W-1:0] load_data;
        logic                    credit_return;
        logic                    out_valid;
        residual_beat_t          out_beat;
        logic                    frame_done;
        logic                    busy;

        integer                  seed = 32'hf278;
        int                      errors = 0;
        int                      cycles = 0;
        string                   test_name = "reset";
        bit                      stream_q[$];           // encoded bits, MSB first
        logic [17:0]             exp_q[$];              // beats still to come
        logic [17:0]             exp_beat;
        int                      res_list[$];
        int                      k_list[16];
        int                      beats;
        int                      outstanding = 0;       // beats not yet paid back
        int                      max_out;
        int                      credit_delay = 0;      // cycles each credit is held
        int                      wait_cnt = 0;
        bit                      frame_seen;

        residual_top i_residual_top (
                .iClock        (iClock),
                .rst           (rst),
                .start         (start),
                .cfg           (cfg),
                .load_we       (load_we),
                .load_addr     (load_addr),
                .load_data     (load_data),
                .credit_return (credit_return),
                .out_valid     (out_valid),
                .out_beat      (out_beat),
                .frame_done    (frame_done),
                .busy          (busy)
        );

        bind residual_decoder residual_assertions i_residual_assertions (
                .iClock        (iClock),
                .rst           (rst),
                .restart       (restart),
                .out_valid     (out_valid),
                .credit_return (credit_return),
                .credits       (credits),
                .frame_done    (frame_done),
                .n_samples     (cfg_q.n_samples),
                .pred_order    (cfg_q.pred_order)
        );

        initial iClock = 1'b0;
        always #4 iClock = ~iClock;

        always @(posedge iClock) begin
                cycles++;
                if (cycles >= 20000) begin
                        $display("run timed out in test %s after %0d cycles", test_name, cycles);
                        $display("errors: %0d", errors);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        task automatic tick;
                @(posedge iClock);
                #1;
        endtask

        task automatic check(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
                if (expected !== actual) begin
                        errors++;
                        $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
                end
        endtask

        // outputs are sampled mid-cycle where they are settled
        always @(negedge iClock) begin
                if (!rst) begin
                        if (out_valid) begin
                                if (outstanding >= `FLAC_CREDITS) begin
                                        errors++;
                                        $display("%s: beat sent with %0d credits outstanding",
                                                 test_name, outstanding);
                                end
                                if (exp_q.size() == 0) begin
                                        errors++;
                                        $display("%s: beat arrived with none expected", test_name);
                                end else begin
                                        exp_beat = exp_q.pop_front();
                                        check(test_name, exp_beat, out_beat);
                                        check(test_name, exp_beat[0], frame_done); // last beat only
                                end
                                beats++;
                        end else if (frame_done) begin
                                errors++;
                                $display("%s: frame_done raised without a beat", test_name);
                        end
                        if (frame_done) begin
                                check(test_name, 1, busy);      // still busy on the last beat
                                frame_seen = 1'b1;
                        end
                        outstanding = outstanding + out_valid - credit_return;
                        if (outstanding > max_out) begin
                                max_out = outstanding;
                        end
                end
        end

        // consumer pays one credit back per beat after credit_delay cycles
        always @(posedge iClock) begin
                #1;
                if (rst) begin
                        credit_return = 1'b0;
                        wait_cnt      = 0;
                end else if (outstanding > 0 && wait_cnt >= credit_delay) begin
                        credit_return = 1'b1;
                        wait_cnt      = 0;
                end else begin
                        credit_return = 1'b0;
                        if (outstanding > 0) begin
                                wait_cnt++;
                        end
                end
        end

        task automatic put_bits(input int value, input int width);
                for (int i = width - 1; i >= 0; i--) begin
                        stream_q.push_back(value[i]);
                end
        endtask

        task automatic put_residual(input int r, input int k);
                int u;
                u = (r >= 0) ? 2 * r : -2 * r - 1;      // zig-zag fold
                repeat (u >> k) stream_q.push_back(1'b0);
                stream_q.push_back(1'b1);               // unary stop bit
                put_bits(u, k);
        endtask

        task automatic encode_job(input int order, input int n, input int pred, input int sbit);
                int  parts;
                int  size;
                int  idx;
                int  r;
                bit  p_last;
                bit  f_last;
                stream_q.delete();
                exp_q.delete();
                idx   = 0;
                parts = 1 << order;
                for (int i = 0; i < sbit; i++) begin
                        stream_q.push_back($random(seed) & 1);  // bits before the job
                end
                put_bits(0, 2);                         // method, plain rice
                put_bits(order, 4);
                for (int p = 0; p < parts; p++) begin
                        size = (n >> order) - ((p == 0) ? pred : 0);
                        put_bits(k_list[p], 4);
                        for (int j = 0; j < size; j++) begin
                                r      = res_list[idx];
                                p_last = (j == size - 1);
                                f_last = p_last && (p == parts - 1);
                                put_residual(r, k_list[p]);
                                exp_q.push_back({r[15:0], p_last, f_last});
                                idx++;
                        end
                end
        endtask

        task automatic load_stream(input int start_word);
                int                      nwords;
                logic [`FLAC_ADDR_W-1:0] addr;
                logic [`FLAC_WORD_W-1:0] word;
                nwords = (stream_q.size() + 15) / 16;
                for (int w = 0; w < nwords + 2; w++) begin
                        addr = start_word + w;
                        word = {addr[3:0], addr} ^ 16'h5a3c;    // tail past the stream
                        for (int b = 0; b < 16; b++) begin
                                if (w * 16 + b < stream_q.size()) begin
                                        word[15-b] = stream_q[w * 16 + b];
                                end
                        end
                        tick;
                        load_we   = 1'b1;
                        load_addr = addr;
                        load_data = word;
                end
                tick;
                load_we = 1'b0;
        endtask

        task automatic run_job(input string name, input int n, input int pred,
                               input int start_word, input int sbit);
                residual_cfg_t c;
                int            expected_beats;
                test_name      = name;
                beats          = 0;
                max_out        = 0;
                frame_seen     = 1'b0;
                expected_beats = exp_q.size();
                c.n_samples    = n;
                c.pred_order   = pred;
                c.start_word   = start_word;
                c.start_bit    = sbit;
                tick;
                cfg   = c;
                start = 1'b1;
                tick;
                start = 1'b0;
                while (!(frame_seen && !busy && outstanding == 0)) begin
                        @(negedge iClock);
                end
                check(name, expected_beats, beats);
                check(name, 0, exp_q.size());
        endtask

        task automatic test_order0;
                res_list  = '{3, -1, 0, 5, -4, 2, -7, 1};
                k_list[0] = 2;
                encode_job(0, 10, 2, 0);
                load_stream(0);
                run_job("order0", 10, 2, 0, 0);
        endtask

        task automatic test_partitions;
                res_list.delete();
                for (int i = 0; i < 22; i++) begin
                        res_list.push_back((i * 7) % 23 - 11);
                end
                k_list[0] = 1;
                k_list[1] = 3;
                k_list[2] = 0;
                k_list[3] = 4;
                encode_job(2, 24, 2, 0);                // sizes 4, 6, 6, 6
                load_stream(100);
                run_job("partitions", 24, 2, 100, 0);
        endtask

        task automatic test_extremes;
                res_list  = '{-1, 0, 1, 15, -15, 0, -1};        // 15 needs q of 30
                k_list[0] = 0;
                encode_job(0, 8, 1, 0);
                load_stream(200);
                run_job("extremes", 8, 1, 200, 0);
        endtask

        task automatic test_backpressure;
                res_list.delete();
                for (int i = 0; i < 32; i++) begin
                        res_list.push_back($random(seed) % 40);
                end
                k_list[0]    = 2;
                k_list[1]    = 5;
                credit_delay = 30;
                encode_job(1, 32, 0, 0);
                load_stream(300);
                run_job("backpressure", 32, 0, 300, 0);
                check("backpressure", `FLAC_CREDITS, max_out);  // window was filled
                credit_delay = 0;
        endtask

        task automatic test_unaligned;
                res_list.delete();
                for (int i = 0; i < 60; i++) begin
                        res_list.push_back($random(seed) % 50);
                end
                for (int p = 0; p < 8; p++) begin
                        k_list[p] = $unsigned($random(seed)) % 6;
                end
                credit_delay = 2;
                encode_job(3, 64, 4, 7);
                load_stream(1000);
                run_job("unaligned", 64, 4, 1000, 7);
                credit_delay = 0;
        endtask

        initial begin
                rst           = 1'b1;
                start         = 1'b0;
                cfg           = '0;
                load_we       = 1'b0;
                load_addr     = '0;
                load_data     = '0;
                credit_return = 1'b0;
                repeat (8) @(posedge iClock);
                #1;
                rst = 1'b0;
                test_order0();
                test_partitions();
                test_extremes();
                test_backpressure();
                test_unaligned();
                errors = errors + i_residual_top.i_residual_decoder.i_residual_assertions.failures;
                $display("errors: %0d", errors);
                if (errors == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

// File: flist.f
+incdir+hdl
hdl/flac_pkg.sv
hdl/stream_ram.sv
hdl/bit_reader.sv
hdl/rice_decoder.sv
hdl/residual_decoder.sv
hdl/residual_top.sv
test/residual_assertions.sv
test/residual_tb.sv

// File: Bender.yml
package:
  name: flac_residual

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/flac_pkg.sv
      - hdl/stream_ram.sv
      - hdl/bit_reader.sv
      - hdl/rice_decoder.sv
      - hdl/residual_decoder.sv
      - hdl/residual_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/residual_assertions.sv
      - test/residual_tb.sv
